// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail on a failing log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_wcache -Mdir obj_dir -f list.f
	./obj_dir/Vtb_wcache +verilator+error+limit+100 | tee sim.log
	@if grep -q "RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== list.f ====
wcache_pkg.sv
wcache_cfg_ctrl.sv
wcache_lookup.sv
wram_fetch_arb.sv
wcache_port_resp.sv
wcache_top.sv
wcache_asserts.sv
tb_wcache.sv

// ==== tb_wcache.sv ====
// Testbench for the weight cache top level, with a weight-RAM model and directed tests
`timescale 1ns/1ps
`default_nettype none

module tb_wcache;
    import wcache_pkg::*;

    localparam int MAX_CYCLES = 3000;   // Five tests take a few hundred cycles

    logic                       clk;
    logic                       rst_n;
    logic                       cfg_valid;
    logic                       cfg_cache_en;
    logic                       cfg_ready;
    port_vec_t                  req_valid;
    wram_addr_t [NUM_PORTS-1:0] req_addr;
    port_vec_t                  req_ready;
    port_vec_t                  resp_valid;
    weight_t [NUM_PORTS-1:0]    resp_data;
    port_vec_t                  resp_ready;
    logic                       wram_addr_valid;
    logic                       wram_addr_ready;
    wram_addr_t                 wram_addr;
    logic                       wram_data_valid;
    weight_t                    wram_data;
    logic                       wram_data_ready;

    int          errors;
    int          checks;
    int          cycles;
    int          rd_count;      // RAM address handshakes
    logic [31:0] seed;
    logic        addr_hs;
    logic        data_hs;
    wram_addr_t  hs_addr;
    wram_addr_t  ram_addr_q;
    int          ram_wait;
    logic        ram_armed;

    wcache_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Weight held by the RAM at an address
    function automatic weight_t model_weight(input wram_addr_t a);
        return a[7:0] ^ {3'b000, a[12:8]};
    endfunction

    // ==========================================================
    // Weight-RAM model, 1 to 4 cycles from address to data
    // ==========================================================
    always @(posedge clk) begin
        addr_hs <= wram_addr_valid & wram_addr_ready;
        hs_addr <= wram_addr;
        data_hs <= wram_data_valid & wram_data_ready;
    end

    always @(negedge clk) begin
        if (data_hs) begin
            wram_data_valid = 1'b0;
        end
        if (addr_hs) begin
            seed       = lcg_next(seed);
            ram_wait   = int'(seed[17:16]);
            ram_addr_q = hs_addr;
            ram_armed  = 1'b1;
            rd_count++;
        end else if (ram_armed && ram_wait > 0) begin
            ram_wait--;
        end
        if (ram_armed && ram_wait == 0) begin
            wram_data_valid = 1'b1;
            wram_data       = model_weight(ram_addr_q);
            ram_armed       = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ==========================================================
    // Compare tasks
    // ==========================================================
    task automatic check_weight(input string what, input weight_t got, input weight_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error t=%0t %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("error t=%0t %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error t=%0t %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err_base);
        $display("test %-22s %s (%0d errors)", name,
                 (errors == err_base) ? "ok" : "FAILED", errors - err_base);
    endtask

    // ==========================================================
    // Channel drivers
    // ==========================================================
    task automatic start_session(input logic en);
        @(negedge clk);
        cfg_valid    = 1'b1;
        cfg_cache_en = en;
        do @(posedge clk); while (!cfg_ready);
        @(negedge clk);
        cfg_valid = 1'b0;
        repeat (2) @(negedge clk);   // CFG, then WORK
    endtask

    task automatic end_session();
        @(negedge clk);
        cfg_valid = 1'b1;
        @(negedge clk);
        cfg_valid = 1'b0;
    endtask

    task automatic send_req(input int p, input wram_addr_t a);
        @(negedge clk);
        req_valid[p] = 1'b1;
        req_addr[p]  = a;
        do @(posedge clk); while (!req_ready[p]);
        @(negedge clk);
        req_valid[p] = 1'b0;
    endtask

    task automatic read_port(input int p, input wram_addr_t a, output weight_t d);
        send_req(p, a);
        do @(posedge clk); while (!(resp_valid[p] && resp_ready[p]));
        d = resp_data[p];
    endtask

    // ==========================================================
    // Directed tests
    // ==========================================================
    task automatic miss_then_hit();
        weight_t d;
        int      base;
        int      e0;
        e0 = errors;
        start_session(1'b1);
        base = rd_count;
        read_port(0, 13'h1a5, d);
        check_weight("resp_data[0] miss", d, model_weight(13'h1a5));
        read_port(0, 13'h1a5, d);
        check_weight("resp_data[0] hit", d, model_weight(13'h1a5));
        check_count("ram reads", rd_count - base, 1);
        report_test("miss then hit", e0);
    endtask

    task automatic bypass_mode();
        weight_t d;
        int      base;
        int      e0;
        e0 = errors;
        end_session();
        start_session(1'b0);
        base = rd_count;
        repeat (3) begin
            read_port(1, 13'h0c37, d);
            check_weight("resp_data[1]", d, model_weight(13'h0c37));
        end
        check_count("ram reads", rd_count - base, 3);   // Every request reaches RAM
        report_test("bypass", e0);
    endtask

    task automatic concurrent_ports();
        wram_addr_t addrs [NUM_PORTS] = '{13'h0210, 13'h0821, 13'h1032, 13'h1843};
        weight_t    d [NUM_PORTS];
        int         base;
        int         e0;
        e0 = errors;
        end_session();
        start_session(1'b1);
        base = rd_count;
        fork
            read_port(0, addrs[0], d[0]);
            read_port(1, addrs[1], d[1]);
            read_port(2, addrs[2], d[2]);
            read_port(3, addrs[3], d[3]);
        join
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_weight($sformatf("resp_data[%0d]", p), d[p], model_weight(addrs[p]));
        end
        check_count("ram reads", rd_count - base, NUM_PORTS);
        read_port(3, addrs[0], d[3]);   // Filled by port 0
        check_weight("resp_data[3] repeat", d[3], model_weight(addrs[0]));
        check_count("ram reads after repeat", rd_count - base, NUM_PORTS);
        report_test("concurrent ports", e0);
    endtask

    task automatic back_pressure();
        weight_t held;
        weight_t d1;
        int      e0;
        e0 = errors;
        @(negedge clk);
        resp_ready[2] = 1'b0;
        send_req(2, 13'h1032);
        do @(posedge clk); while (!resp_valid[2]);
        held = resp_data[2];
        check_weight("resp_data[2]", held, model_weight(13'h1032));
        @(negedge clk);
        req_valid[2] = 1'b1;            // Must wait behind the full register
        req_addr[2]  = 13'h0777;
        fork
            begin
                read_port(1, 13'h0456, d1);
                check_weight("resp_data[1] miss", d1, model_weight(13'h0456));
                read_port(1, 13'h0821, d1);
                check_weight("resp_data[1] hit", d1, model_weight(13'h0821));
            end
            repeat (8) begin
                @(posedge clk);
                check_flag("resp_valid[2]", resp_valid[2], 1'b1);
                check_weight("resp_data[2] held", resp_data[2], held);
                check_flag("req_ready[2]", req_ready[2], 1'b0);
            end
        join
        @(negedge clk);
        resp_ready[2] = 1'b1;
        req_valid[2]  = 1'b0;
        @(negedge clk);
        report_test("back-pressure", e0);
    endtask

    task automatic replace_and_restart();
        wram_addr_t a;
        weight_t    d;
        int         base;
        int         e0;
        e0 = errors;
        end_session();
        start_session(1'b1);
        for (int i = 0; i < CACHE_DEPTH + 1; i++) begin
            a = wram_addr_t'(13'h0a00 + i * 3);
            read_port(0, a, d);
            check_weight("resp_data[0] fill", d, model_weight(a));
        end
        base = rd_count;
        read_port(0, 13'h0a00, d);      // Entry 0 was reused by the ninth fill
        check_weight("resp_data[0] evicted", d, model_weight(13'h0a00));
        check_count("ram reads after eviction", rd_count - base, 1);
        base = rd_count;
        read_port(0, 13'h0a06, d);
        check_weight("resp_data[0] cached", d, model_weight(13'h0a06));
        check_count("ram reads on cached entry", rd_count - base, 0);
        end_session();
        check_flag("cfg_ready in IDLE", cfg_ready, 1'b1);
        start_session(1'b1);
        base = rd_count;
        read_port(0, 13'h0a06, d);      // Cache was cleared with the session
        check_weight("resp_data[0] new session", d, model_weight(13'h0a06));
        check_count("ram reads in new session", rd_count - base, 1);
        report_test("replacement and restart", e0);
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================
    initial begin
        rst_n           = 1'b0;
        cfg_valid       = 1'b0;
        cfg_cache_en    = 1'b0;
        req_valid       = '0;
        req_addr        = '0;
        resp_ready      = '1;
        wram_addr_ready = 1'b1;
        wram_data_valid = 1'b0;
        wram_data       = '0;
        errors          = 0;
        checks          = 0;
        cycles          = 0;
        rd_count        = 0;
        seed            = 32'h250b;
        addr_hs         = 1'b0;
        data_hs         = 1'b0;
        hs_addr         = '0;
        ram_addr_q      = '0;
        ram_wait        = 0;
        ram_armed       = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_flag("cfg_ready", cfg_ready, 1'b1);
        check_flag("req_ready", |req_ready, 1'b0);
        check_flag("resp_valid", |resp_valid, 1'b0);
        check_flag("wram_addr_valid", wram_addr_valid, 1'b0);
        check_flag("wram_data_ready", wram_data_ready, 1'b0);
        report_test("reset values", 0);
        miss_then_hit();
        bypass_mode();
        concurrent_ports();
        back_pressure();
        replace_and_restart();
        errors += dut_i.fetch_arb_i.asserts_i.fail_count;
        $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== wcache_asserts.sv ====
// Concurrent checks on the RAM arbiter's handshake rules, bound into wram_fetch_arb
`timescale 1ns/1ps
`default_nettype none

module wcache_asserts (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  rd_pending,
    input logic                  wram_addr_valid,
    input wcache_pkg::port_vec_t resp_free,
    input wcache_pkg::port_vec_t ram_load
);
    int fail_count = 0;   // Summed into the testbench error count

    // No new address while a read is in flight
    addr_while_pending: assert property (@(posedge clk) disable iff (!rst_n)
        rd_pending |-> !wram_addr_valid)
        else begin
            fail_count++;
            $error("wram_addr_valid high with a read outstanding");
        end

    // RAM data only lands in a response register that is empty or draining
    reload_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        (~resp_free & ram_load) == '0)
        else begin
            fail_count++;
            $error("RAM data loaded into a response register that is valid and not ready");
        end

    ram_load_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(ram_load))
        else begin
            fail_count++;
            $error("more than one ram_load bit high");
        end

endmodule

bind wram_fetch_arb wcache_asserts asserts_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .rd_pending      (rd_pending),
    .wram_addr_valid (wram_addr_valid),
    .resp_free       (resp_free),
    .ram_load        (ram_load)
);

`default_nettype wire

// ==== wcache_cfg_ctrl.sv ====
// Session FSM and cache/bypass mode register, driven by the configuration handshake
`timescale 1ns/1ps
`default_nettype none

module wcache_cfg_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic cfg_valid,
    input  logic cfg_cache_en,
    output logic cfg_ready,
    output logic work,
    output logic cache_en
);
    import wcache_pkg::*;

    session_state_t state_q;
    session_state_t state_d;
    logic           cfg_fire;

    assign cfg_ready = (state_q == IDLE);
    assign cfg_fire  = cfg_valid & cfg_ready;
    assign work      = (state_q == WORK);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cfg_fire) begin
                    state_d = CFG;
                end
            end
            CFG: begin
                state_d = WORK;
            end
            WORK: begin
                if (cfg_valid) begin   // Second config ends the session
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= IDLE;
            cache_en <= 1'b0;
        end else begin
            state_q <= state_d;
            if (cfg_fire) begin
                cache_en <= cfg_cache_en;   // Mode captured at acceptance
            end else if (state_q == IDLE) begin
                cache_en <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== wcache_lookup.sv ====
// Fully associative weight cache with per-port tag compare and round-robin fill
`timescale 1ns/1ps
`default_nettype none

module wcache_lookup (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           work,
    input  logic                                           cache_en,
    input  wcache_pkg::wram_addr_t [wcache_pkg::NUM_PORTS-1:0] req_addr,
    output wcache_pkg::port_vec_t                          hit,
    output wcache_pkg::weight_t [wcache_pkg::NUM_PORTS-1:0] hit_data,
    input  logic                                           fill_valid,
    input  wcache_pkg::wram_addr_t                         fill_addr,
    input  wcache_pkg::weight_t                            fill_data
);
    import wcache_pkg::*;

    // ==========================================================
    // Storage
    // ==========================================================
    wram_addr_t             tag_q  [CACHE_DEPTH];
    weight_t                data_q [CACHE_DEPTH];
    logic [CACHE_DEPTH-1:0] valid_q;
    cache_idx_t             repl_ptr_q;   // Next victim

    logic [CACHE_IDX_W:0]   fill_match;   // {found, entry}
    logic                   fill_write;

    // Lowest matching valid entry, found flag in the MSB
    function automatic logic [CACHE_IDX_W:0] find_entry(input wram_addr_t addr);
        logic [CACHE_IDX_W:0] res;
        res = '0;
        for (int e = CACHE_DEPTH - 1; e >= 0; e--) begin
            if (valid_q[e] && (tag_q[e] == addr)) begin
                res = {1'b1, cache_idx_t'(e)};
            end
        end
        return res;
    endfunction

    // ==========================================================
    // Per-port compare
    // ==========================================================
    always_comb begin
        logic [CACHE_IDX_W:0] m;
        for (int p = 0; p < NUM_PORTS; p++) begin
            m           = find_entry(req_addr[p]);
            hit[p]      = cache_en & m[CACHE_IDX_W];   // Bypass mode never hits
            hit_data[p] = data_q[m[CACHE_IDX_W-1:0]];
        end
    end

    // ==========================================================
    // Fill
    // ==========================================================
    assign fill_match = find_entry(fill_addr);
    assign fill_write = fill_valid & cache_en & work & ~fill_match[CACHE_IDX_W];

    always_ff @(posedge clk) begin
        if (fill_write) begin
            tag_q[repl_ptr_q]  <= fill_addr;
            data_q[repl_ptr_q] <= fill_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q    <= '0;
            repl_ptr_q <= '0;
        end else if (!work) begin
            valid_q    <= '0;   // Session over, drop everything
            repl_ptr_q <= '0;
        end else if (fill_write) begin
            valid_q[repl_ptr_q] <= 1'b1;
            repl_ptr_q          <= cache_idx_t'(repl_ptr_q + 1'b1);
        end
    end

endmodule

`default_nettype wire

// ==== wcache_pkg.sv ====
// Shared widths, counts and session encoding for the weight cache RTL and its testbench
`default_nettype none

package wcache_pkg;

    // ==========================================================
    // Sizes
    // ==========================================================
    localparam int NUM_PORTS   = 4;                  // PE rows
    localparam int PORT_IDX_W  = $clog2(NUM_PORTS);
    localparam int WRAM_ADDR_W = 13;
    localparam int WEIGHT_W    = 8;
    localparam int CACHE_DEPTH = 8;                  // Fully associative entries
    localparam int CACHE_IDX_W = $clog2(CACHE_DEPTH);

    // ==========================================================
    // Types
    // ==========================================================
    // Weight-RAM word address
    typedef logic [WRAM_ADDR_W-1:0] wram_addr_t;

    // One weight
    typedef logic [WEIGHT_W-1:0] weight_t;

    // Port number and per-port flag vector
    typedef logic [PORT_IDX_W-1:0] port_idx_t;
    typedef logic [NUM_PORTS-1:0]  port_vec_t;

    // Cache entry number
    typedef logic [CACHE_IDX_W-1:0] cache_idx_t;

    // Session machine
    typedef enum logic [1:0] {
        IDLE = 2'd0,    // Waiting for a configuration
        CFG  = 2'd1,    // One cycle after acceptance
        WORK = 2'd2     // Requests are served
    } session_state_t;

endpackage

`default_nettype wire

// ==== wcache_port_resp.sv ====
// One-entry response register per port, loaded from cache or RAM, with valid/ready output
`timescale 1ns/1ps
`default_nettype none

module wcache_port_resp (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                work,
    input  logic                hit_load,
    input  logic                ram_load,
    input  wcache_pkg::weight_t hit_data,
    input  wcache_pkg::weight_t ram_data,
    input  logic                resp_ready,
    output logic                resp_valid,
    output wcache_pkg::weight_t resp_data,
    output logic                resp_free
);
    import wcache_pkg::*;

    logic    load;
    weight_t load_data;

    assign load      = hit_load | ram_load;
    assign load_data = ram_load ? ram_data : hit_data;   // Never both at once
    assign resp_free = ~resp_valid | resp_ready;         // Empty or draining

    // Payload
    always_ff @(posedge clk) begin
        if (load) begin
            resp_data <= load_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else if (!work) begin
            resp_valid <= 1'b0;
        end else if (load) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== wcache_top.sv ====
// Weight cache top level, joins the session control, cache lookup, RAM arbiter and port outputs
`timescale 1ns/1ps
`default_nettype none

module wcache_top (
    input  logic                                           clk,
    input  logic                                           rst_n,
    // Configuration
    input  logic                                           cfg_valid,
    input  logic                                           cfg_cache_en,
    output logic                                           cfg_ready,
    // PE requests
    input  wcache_pkg::port_vec_t                          req_valid,
    input  wcache_pkg::wram_addr_t [wcache_pkg::NUM_PORTS-1:0] req_addr,
    output wcache_pkg::port_vec_t                          req_ready,
    // PE responses
    output wcache_pkg::port_vec_t                          resp_valid,
    output wcache_pkg::weight_t [wcache_pkg::NUM_PORTS-1:0] resp_data,
    input  wcache_pkg::port_vec_t                          resp_ready,
    // Weight RAM
    output logic                                           wram_addr_valid,
    input  logic                                           wram_addr_ready,
    output wcache_pkg::wram_addr_t                         wram_addr,
    input  logic                                           wram_data_valid,
    input  wcache_pkg::weight_t                            wram_data,
    output logic                                           wram_data_ready
);
    import wcache_pkg::*;

    logic                           work;
    logic                           cache_en;
    port_vec_t                      hit;
    weight_t [NUM_PORTS-1:0]        hit_data;
    port_vec_t                      hit_load;
    port_vec_t                      ram_load;
    port_vec_t                      resp_free;
    logic                           fill_valid;
    wram_addr_t                     fill_addr;

    wcache_cfg_ctrl cfg_ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_valid    (cfg_valid),
        .cfg_cache_en (cfg_cache_en),
        .cfg_ready    (cfg_ready),
        .work         (work),
        .cache_en     (cache_en)
    );

    wcache_lookup lookup_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .work       (work),
        .cache_en   (cache_en),
        .req_addr   (req_addr),
        .hit        (hit),
        .hit_data   (hit_data),
        .fill_valid (fill_valid),
        .fill_addr  (fill_addr),
        .fill_data  (wram_data)      // Fill straight from the RAM return
    );

    wram_fetch_arb fetch_arb_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .work            (work),
        .req_valid       (req_valid),
        .req_addr        (req_addr),
        .hit             (hit),
        .resp_free       (resp_free),
        .req_ready       (req_ready),
        .hit_load        (hit_load),
        .ram_load        (ram_load),
        .wram_addr_valid (wram_addr_valid),
        .wram_addr_ready (wram_addr_ready),
        .wram_addr       (wram_addr),
        .wram_data_valid (wram_data_valid),
        .wram_data_ready (wram_data_ready),
        .fill_valid      (fill_valid),
        .fill_addr       (fill_addr)
    );

    // ==========================================================
    // Per-port response registers
    // ==========================================================
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        wcache_port_resp port_resp_i (
            .clk        (clk),
            .rst_n      (rst_n),
            .work       (work),
            .hit_load   (hit_load[p]),
            .ram_load   (ram_load[p]),
            .hit_data   (hit_data[p]),
            .ram_data   (wram_data),
            .resp_ready (resp_ready[p]),
            .resp_valid (resp_valid[p]),
            .resp_data  (resp_data[p]),
            .resp_free  (resp_free[p])
        );
    end

endmodule

`default_nettype wire

// ==== wram_fetch_arb.sv ====
// Request acceptance, round-robin miss arbitration and single outstanding weight-RAM read
`timescale 1ns/1ps
`default_nettype none

module wram_fetch_arb (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           work,
    input  wcache_pkg::port_vec_t                          req_valid,
    input  wcache_pkg::wram_addr_t [wcache_pkg::NUM_PORTS-1:0] req_addr,
    input  wcache_pkg::port_vec_t                          hit,
    input  wcache_pkg::port_vec_t                          resp_free,
    output wcache_pkg::port_vec_t                          req_ready,
    output wcache_pkg::port_vec_t                          hit_load,
    output wcache_pkg::port_vec_t                          ram_load,
    output logic                                           wram_addr_valid,
    input  logic                                           wram_addr_ready,
    output wcache_pkg::wram_addr_t                         wram_addr,
    input  logic                                           wram_data_valid,
    output logic                                           wram_data_ready,
    output logic                                           fill_valid,
    output wcache_pkg::wram_addr_t                         fill_addr
);
    import wcache_pkg::*;

    logic       rd_pending;     // One read in flight
    port_idx_t  rd_port_q;
    wram_addr_t rd_addr_q;
    port_idx_t  rr_ptr_q;       // Highest priority port
    port_vec_t  busy;           // Port waiting for its RAM data
    port_vec_t  miss;
    port_idx_t  grant_idx;
    logic       grant_any;
    logic       issue;
    logic       data_fire;

    // ==========================================================
    // Round-robin pick among missing ports
    // ==========================================================
    always_comb begin
        port_idx_t cand;
        grant_any = 1'b0;
        grant_idx = '0;
        for (int i = NUM_PORTS - 1; i >= 0; i--) begin   // Lowest offset wins
            cand = port_idx_t'((int'(rr_ptr_q) + i) % NUM_PORTS);
            if (miss[cand]) begin
                grant_any = 1'b1;
                grant_idx = cand;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            busy[p] = rd_pending & (rd_port_q == port_idx_t'(p));
            miss[p] = work & req_valid[p] & ~hit[p] & resp_free[p] & ~busy[p];
        end
    end

    assign wram_addr_valid = grant_any & ~rd_pending;
    assign wram_addr       = req_addr[grant_idx];
    assign issue           = wram_addr_valid & wram_addr_ready;

    // Hit or granted miss, and a free response slot
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            req_ready[p] = work & resp_free[p] & ~busy[p]
                         & (hit[p] | (issue & (grant_idx == port_idx_t'(p))));
            hit_load[p]  = req_valid[p] & req_ready[p] & hit[p];
            ram_load[p]  = data_fire & (rd_port_q == port_idx_t'(p));
        end
    end

    // ==========================================================
    // Outstanding read
    // ==========================================================
    assign wram_data_ready = rd_pending;
    assign data_fire       = wram_data_valid & rd_pending;
    assign fill_valid      = data_fire;
    assign fill_addr       = rd_addr_q;

    always_ff @(posedge clk) begin
        if (issue) begin
            rd_port_q <= grant_idx;
            rd_addr_q <= wram_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pending <= 1'b0;
            rr_ptr_q   <= '0;
        end else begin
            // Kept across session end so the RAM still gets drained
            if (issue) begin
                rd_pending <= 1'b1;
            end else if (data_fire) begin
                rd_pending <= 1'b0;
            end
            if (!work) begin
                rr_ptr_q <= '0;
            end else if (issue) begin
                rr_ptr_q <= port_idx_t'((int'(grant_idx) + 1) % NUM_PORTS);
            end
        end
    end

endmodule

`default_nettype wire
